// ==== source/pinballPkg.sv ====
package pinballPkg;

	// Start position of the ball in pixels.
	localparam logic signed [10:0] ballInitialX = 11'sd300;
	localparam logic signed [10:0] ballInitialY = 11'sd50;

	// Speed and position carry this many fraction bits.
	localparam int fixedPointShift = 6;
	localparam int fixedPointMultiplier = 1 << fixedPointShift;

	// Start position in fixed-point units.
	localparam logic signed [31:0] ballStartFixedX = ballInitialX * fixedPointMultiplier;
	localparam logic signed [31:0] ballStartFixedY = ballInitialY * fixedPointMultiplier;

	// Added to the Y speed once per frame.
	localparam logic signed [31:0] gravity = 32'sd4;

	localparam int apbAddrWidth = 4;

	localparam logic [apbAddrWidth-1:0] addrControl      = 4'h0;
	localparam logic [apbAddrWidth-1:0] addrFlipperSpeed = 4'h4;
	localparam logic [apbAddrWidth-1:0] addrSpringSpeed  = 4'h8;
	localparam logic [apbAddrWidth-1:0] addrBumperFactor = 4'hC;

	typedef struct packed {
		logic signed [7:0] xxFactor;
		logic signed [7:0] xyFactor;
		logic signed [7:0] yxFactor;
		logic signed [7:0] yyFactor;
	} collisionFactorT;

	// Same bit order as the detectors, left in bit 3 and bottom in bit 0.
	typedef struct packed {
		logic left;
		logic top;
		logic right;
		logic bottom;
	} edgeCodeT;

	typedef enum logic [2:0] {
		none    = 3'd0,
		wall    = 3'd1, // Frame and obstacle hits.
		spring  = 3'd2,
		flipper = 3'd3,
		bumper  = 3'd4
	} eventKindT;

	typedef struct packed {
		eventKindT kind;
		edgeCodeT  hitEdge;
	} collisionEventT;

	typedef struct packed {
		logic               pause;
		logic signed [31:0] flipperSpeedX;
		logic signed [31:0] springSpeedY;
		collisionFactorT    collisionFactor;
	} gameConfigT;

	typedef struct packed {
		logic signed [10:0] x;
		logic signed [10:0] y;
	} ballPositionT;

endpackage

// ==== source/apbRegisters.sv ====
module apbRegisters (
	input  logic                                clk,
	input  logic                                resetN,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [pinballPkg::apbAddrWidth-1:0] paddr,
	input  logic [31:0]                         pwdata,
	output logic [31:0]                         prdata,
	output logic                                pready,
	output pinballPkg::gameConfigT              gameConfig,
	output logic                                levelRestart
);

	logic access;
	logic writeAccess;

	assign access = psel && penable;
	assign writeAccess = access && pwrite;

	assign pready = 1'b1; // No wait states.

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			gameConfig.pause <= 1'b0;
			gameConfig.flipperSpeedX <= '0;
			gameConfig.springSpeedY <= '0;
			gameConfig.collisionFactor <= '0;
		end else if (writeAccess) begin
			case (paddr)
				pinballPkg::addrControl: begin
					gameConfig.pause <= pwdata[0];
				end
				pinballPkg::addrFlipperSpeed: begin
					gameConfig.flipperSpeedX <= pwdata;
				end
				pinballPkg::addrSpringSpeed: begin
					gameConfig.springSpeedY <= pwdata;
				end
				pinballPkg::addrBumperFactor: begin
					gameConfig.collisionFactor <= pwdata;
				end
				default: begin
				end
			endcase
		end
	end

	// Restart bit is write-only and lasts one cycle.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			levelRestart <= 1'b0;
		end else begin
			levelRestart <= writeAccess && (paddr == pinballPkg::addrControl) && pwdata[1];
		end
	end

	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			case (paddr)
				pinballPkg::addrControl: begin
					prdata = {31'b0, gameConfig.pause}; // Restart reads as 0.
				end
				pinballPkg::addrFlipperSpeed: begin
					prdata = gameConfig.flipperSpeedX;
				end
				pinballPkg::addrSpringSpeed: begin
					prdata = gameConfig.springSpeedY;
				end
				pinballPkg::addrBumperFactor: begin
					prdata = gameConfig.collisionFactor;
				end
				default: begin
					prdata = '0;
				end
			endcase
		end
	end

	// The access phase always follows a setup phase with psel high.
	penableNeedsPsel: assert property (
		@(posedge clk) disable iff (!resetN)
		$rose(penable) |-> psel
	) else $error("penable rose without psel");

endmodule

// ==== source/collisionArbiter.sv ====
module collisionArbiter (
	input  logic                       clk,
	input  logic                       resetN,
	input  logic                       collisionFrame,
	input  logic                       collisionObstacle,
	input  logic                       collisionSpring,
	input  logic                       collisionFlipper,
	input  logic                       collisionBumper,
	input  pinballPkg::edgeCodeT       hitEdgeCode,
	output pinballPkg::collisionEventT collisionEvent
);

	logic anyFlag;
	pinballPkg::eventKindT nextKind;

	assign anyFlag = collisionFrame || collisionObstacle || collisionSpring ||
		collisionFlipper || collisionBumper;

	// Fixed priority, wall first.
	always_comb begin
		if (collisionFrame || collisionObstacle) begin
			nextKind = pinballPkg::wall;
		end else if (collisionSpring) begin
			nextKind = pinballPkg::spring;
		end else if (collisionFlipper) begin
			nextKind = pinballPkg::flipper;
		end else if (collisionBumper) begin
			nextKind = pinballPkg::bumper;
		end else begin
			nextKind = pinballPkg::none;
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			collisionEvent.kind <= pinballPkg::none;
			collisionEvent.hitEdge <= '0;
		end else begin
			collisionEvent.kind <= nextKind;
			collisionEvent.hitEdge <= hitEdgeCode;
		end
	end

	noFlagNoEvent: assert property (
		@(posedge clk) disable iff (!resetN)
		!anyFlag |=> (collisionEvent.kind == pinballPkg::none)
	) else $error("Collision event without a raw flag");

endmodule

// ==== source/ballController.sv ====
module ballController (
	input  logic                       clk,
	input  logic                       resetN,
	input  logic                       startOfFrame,
	input  logic                       levelRestart,
	input  pinballPkg::gameConfigT     gameConfig,
	input  pinballPkg::collisionEventT collisionEvent,
	output logic signed [31:0]         ballFixedX,
	output logic signed [31:0]         ballFixedY
);

	logic signed [31:0] speedX;
	logic signed [31:0] speedY;
	logic signed [31:0] factorXX;
	logic signed [31:0] factorXY;
	logic signed [31:0] factorYX;
	logic signed [31:0] factorYY;
	logic signed [31:0] bumperSpeedX;
	logic signed [31:0] bumperSpeedY;
	pinballPkg::edgeCodeT hitEdge;

	assign hitEdge = collisionEvent.hitEdge;

	// Sign-extended bumper factors.
	assign factorXX = gameConfig.collisionFactor.xxFactor;
	assign factorXY = gameConfig.collisionFactor.xyFactor;
	assign factorYX = gameConfig.collisionFactor.yxFactor;
	assign factorYY = gameConfig.collisionFactor.yyFactor;

	// Both mixes use the old speeds.
	assign bumperSpeedX = (speedX * factorXX + speedY * factorYX) >>> 1;
	assign bumperSpeedY = (speedY * factorYY + speedX * factorXY) >>> 1;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speedX <= '0;
			speedY <= '0;
			ballFixedX <= pinballPkg::ballStartFixedX;
			ballFixedY <= pinballPkg::ballStartFixedY;
		end else if (levelRestart) begin
			speedX <= '0;
			speedY <= '0;
			ballFixedX <= pinballPkg::ballStartFixedX;
			ballFixedY <= pinballPkg::ballStartFixedY;
		end else if (!gameConfig.pause) begin
			if (startOfFrame) begin
				speedY <= speedY + pinballPkg::gravity;
				ballFixedX <= ballFixedX + speedX; // Old speed moves the ball.
				ballFixedY <= ballFixedY + speedY;
			end else begin
				case (collisionEvent.kind)
					pinballPkg::wall: begin
						if (hitEdge.top && (speedY < 0)) begin
							speedY <= -speedY;
						end else if (hitEdge.bottom && (speedY > 0)) begin
							speedY <= -speedY;
						end
						if (hitEdge.left && (speedX < 0)) begin
							speedX <= -speedX;
						end else if (hitEdge.right && (speedX > 0)) begin
							speedX <= -speedX;
						end
					end
					pinballPkg::spring: begin
						if (hitEdge.bottom) begin
							if (gameConfig.springSpeedY < 0) begin
								speedY <= speedY + gameConfig.springSpeedY; // Launch.
							end else begin
								speedY <= -speedY;
							end
						end
					end
					pinballPkg::flipper: begin
						if (hitEdge.bottom && (speedY > 0)) begin
							speedY <= -speedY;
							speedX <= speedX + gameConfig.flipperSpeedX;
						end
					end
					pinballPkg::bumper: begin
						speedX <= bumperSpeedX;
						speedY <= bumperSpeedY;
					end
					default: begin
					end
				endcase
			end
		end
	end

	restartToStart: assert property (
		@(posedge clk) disable iff (!resetN)
		levelRestart |=> (ballFixedX == pinballPkg::ballStartFixedX) &&
			(ballFixedY == pinballPkg::ballStartFixedY) &&
			(speedX == 0) && (speedY == 0)
	) else $error("Level restart did not return the ball to the start");

endmodule

// ==== source/positionPublisher.sv ====
module positionPublisher (
	input  logic                     clk,
	input  logic                     resetN,
	input  logic                     startOfFrame,
	input  logic signed [31:0]       ballFixedX,
	input  logic signed [31:0]       ballFixedY,
	output pinballPkg::ballPositionT position,
	output logic                     positionValid
);

	logic frameDelay;
	logic signed [31:0] pixelX;
	logic signed [31:0] pixelY;

	// Drop the fraction bits, keeping the sign.
	assign pixelX = ballFixedX >>> pinballPkg::fixedPointShift;
	assign pixelY = ballFixedY >>> pinballPkg::fixedPointShift;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			frameDelay <= 1'b0;
			positionValid <= 1'b0;
		end else begin
			frameDelay <= startOfFrame; // Frame step has landed by now.
			positionValid <= frameDelay;
		end
	end

	always_ff @(posedge clk) begin
		if (frameDelay) begin
			position.x <= 11'(pixelX);
			position.y <= 11'(pixelY);
		end
	end

endmodule

// ==== source/pinballTop.sv ====
module pinballTop (
	input  logic                                clk,
	input  logic                                resetN,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [pinballPkg::apbAddrWidth-1:0] paddr,
	input  logic [31:0]                         pwdata,
	output logic [31:0]                         prdata,
	output logic                                pready,
	input  logic                                startOfFrame,
	input  logic                                collisionFrame,
	input  logic                                collisionObstacle,
	input  logic                                collisionSpring,
	input  logic                                collisionFlipper,
	input  logic                                collisionBumper,
	input  pinballPkg::edgeCodeT                hitEdgeCode,
	output pinballPkg::ballPositionT            position,
	output logic                                positionValid
);

	pinballPkg::gameConfigT gameConfig;
	pinballPkg::collisionEventT collisionEvent;
	logic levelRestart;
	logic signed [31:0] ballFixedX;
	logic signed [31:0] ballFixedY;

	apbRegisters u_apbRegisters (
		.clk          (clk),
		.resetN       (resetN),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.gameConfig   (gameConfig),
		.levelRestart (levelRestart)
	);

	collisionArbiter u_collisionArbiter (
		.clk               (clk),
		.resetN            (resetN),
		.collisionFrame    (collisionFrame),
		.collisionObstacle (collisionObstacle),
		.collisionSpring   (collisionSpring),
		.collisionFlipper  (collisionFlipper),
		.collisionBumper   (collisionBumper),
		.hitEdgeCode       (hitEdgeCode),
		.collisionEvent    (collisionEvent)
	);

	ballController u_ballController (
		.clk            (clk),
		.resetN         (resetN),
		.startOfFrame   (startOfFrame),
		.levelRestart   (levelRestart),
		.gameConfig     (gameConfig),
		.collisionEvent (collisionEvent),
		.ballFixedX     (ballFixedX),
		.ballFixedY     (ballFixedY)
	);

	positionPublisher u_positionPublisher (
		.clk           (clk),
		.resetN        (resetN),
		.startOfFrame  (startOfFrame),
		.ballFixedX    (ballFixedX),
		.ballFixedY    (ballFixedY),
		.position      (position),
		.positionValid (positionValid)
	);

endmodule

// ==== verification/clockGen.sv ====
module clockGen (
	output logic clk,
	output logic resetN
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // Period of 20.
	end

	// Reset held low for the first 10 cycles.
	initial begin
		resetN = 1'b0;
		repeat (10) @(negedge clk);
		resetN = 1'b1;
	end

endmodule

// ==== verification/pinballChecker.sv ====
module pinballChecker (
	input  logic                                clk,
	input  logic                                resetN,
	input  logic [8*12-1:0]                     testName,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [pinballPkg::apbAddrWidth-1:0] paddr,
	input  logic [31:0]                         pwdata,
	input  logic [31:0]                         prdata,
	input  logic                                pready,
	input  logic                                startOfFrame,
	input  logic                                collisionFrame,
	input  logic                                collisionObstacle,
	input  logic                                collisionSpring,
	input  logic                                collisionFlipper,
	input  logic                                collisionBumper,
	input  pinballPkg::edgeCodeT                hitEdgeCode,
	input  pinballPkg::ballPositionT            position,
	input  logic                                positionValid,
	output int                                  errorCount,
	output int                                  positionChecks
);

	int speedX;
	int speedY;
	int posX;
	int posY;
	int mixX;
	int mixY;
	logic pause;
	int flipperSpeed;
	int springSpeed;
	pinballPkg::collisionFactorT factors;
	logic restartPending;
	pinballPkg::collisionEventT pending;
	logic frameSeen;
	logic validExpected;
	pinballPkg::ballPositionT expectedPosition;

	function automatic logic [31:0] registerValue(input logic [3:0] address);
		case (address)
			pinballPkg::addrControl: return {31'b0, pause};
			pinballPkg::addrFlipperSpeed: return flipperSpeed;
			pinballPkg::addrSpringSpeed: return springSpeed;
			pinballPkg::addrBumperFactor: return factors;
			default: return 32'h0;
		endcase
	endfunction

	task automatic restartBall();
		speedX = 0;
		speedY = 0;
		posX = int'(pinballPkg::ballInitialX) * (1 << pinballPkg::fixedPointShift);
		posY = int'(pinballPkg::ballInitialY) * (1 << pinballPkg::fixedPointShift);
	endtask

	task automatic resetModel();
		restartBall();
		pause = 1'b0;
		flipperSpeed = 0;
		springSpeed = 0;
		factors = '0;
		restartPending = 1'b0;
		pending = '0;
		frameSeen = 1'b0;
		validExpected = 1'b0;
	endtask

	// One clock edge of the ball rules, on the state before the edge.
	task automatic stepBall();
		if (restartPending) begin
			restartBall();
		end else if (!pause && startOfFrame) begin
			posX = posX + speedX; // Old speed moves the ball.
			posY = posY + speedY;
			speedY = speedY + pinballPkg::gravity;
		end else if (!pause) begin
			case (pending.kind)
				pinballPkg::wall: begin
					if ((pending.hitEdge.top && speedY < 0) ||
						(pending.hitEdge.bottom && speedY > 0)) begin
						speedY = -speedY;
					end
					if ((pending.hitEdge.left && speedX < 0) ||
						(pending.hitEdge.right && speedX > 0)) begin
						speedX = -speedX;
					end
				end
				pinballPkg::spring: begin
					if (pending.hitEdge.bottom) begin
						speedY = (springSpeed < 0) ? speedY + springSpeed : -speedY;
					end
				end
				pinballPkg::flipper: begin
					if (pending.hitEdge.bottom && speedY > 0) begin
						speedY = -speedY;
						speedX = speedX + flipperSpeed;
					end
				end
				pinballPkg::bumper: begin
					mixX = (speedX * factors.xxFactor + speedY * factors.yxFactor) >>> 1;
					mixY = (speedY * factors.yyFactor + speedX * factors.xyFactor) >>> 1;
					speedX = mixX;
					speedY = mixY;
				end
				default: begin
				end
			endcase
		end
	endtask

	initial begin
		errorCount = 0;
		positionChecks = 0;
		resetModel();
	end

	always @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			resetModel();
		end else begin
			if (pready !== 1'b1) begin
				errorCount = errorCount + 1;
				$display("ERROR %0s: pready expected 1, actual %b", testName, pready);
			end
			if (positionValid !== validExpected) begin
				errorCount = errorCount + 1;
				$display("ERROR %0s: positionValid expected %b, actual %b",
					testName, validExpected, positionValid);
			end
			if (validExpected) begin
				positionChecks = positionChecks + 1;
				if (position !== expectedPosition) begin
					errorCount = errorCount + 1;
					$display("ERROR %0s: expected position (%0d, %0d), actual (%0d, %0d)",
						testName, expectedPosition.x, expectedPosition.y,
						position.x, position.y);
				end
			end
			if (psel && penable && !pwrite && prdata !== registerValue(paddr)) begin
				errorCount = errorCount + 1;
				$display("ERROR %0s: read of %h expected %h, actual %h",
					testName, paddr, registerValue(paddr), prdata);
			end
			// Publisher sees the position one edge after the frame step.
			validExpected = frameSeen;
			if (frameSeen) begin
				expectedPosition.x = 11'(posX >>> pinballPkg::fixedPointShift);
				expectedPosition.y = 11'(posY >>> pinballPkg::fixedPointShift);
			end
			frameSeen = startOfFrame;
			stepBall();
			if (collisionFrame || collisionObstacle) begin
				pending.kind = pinballPkg::wall;
			end else if (collisionSpring) begin
				pending.kind = pinballPkg::spring;
			end else if (collisionFlipper) begin
				pending.kind = pinballPkg::flipper;
			end else if (collisionBumper) begin
				pending.kind = pinballPkg::bumper;
			end else begin
				pending.kind = pinballPkg::none;
			end
			pending.hitEdge = hitEdgeCode;
			restartPending = psel && penable && pwrite &&
				paddr == pinballPkg::addrControl && pwdata[1];
			if (psel && penable && pwrite) begin
				case (paddr)
					pinballPkg::addrControl: pause = pwdata[0];
					pinballPkg::addrFlipperSpeed: flipperSpeed = pwdata;
					pinballPkg::addrSpringSpeed: springSpeed = pwdata;
					pinballPkg::addrBumperFactor: factors = pwdata;
					default: begin
					end
				endcase
			end
		end
	end

endmodule

// ==== verification/pinballTb.sv ====
module pinballTb;

	typedef struct packed {
		logic [8*12-1:0]      name;
		logic                 doWrite;
		logic                 readBack;
		logic                 randomData;
		logic [3:0]           addr;
		logic [31:0]          data;
		logic [4:0]           flags; // Frame, obstacle, spring, flipper, bumper.
		pinballPkg::edgeCodeT edges;
		logic                 randomFrames;
		logic [3:0]           frames;
	} stepT;

	logic clk;
	logic resetN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [pinballPkg::apbAddrWidth-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic startOfFrame;
	logic [4:0] flags;
	pinballPkg::edgeCodeT hitEdgeCode;
	pinballPkg::ballPositionT position;
	logic positionValid;
	logic [8*12-1:0] testName;
	int errorCount;
	int positionChecks;
	int cycleCount;
	int cycleLimit;
	stepT steps [13];

	clockGen u_clockGen (.clk(clk), .resetN(resetN));

	pinballTop u_dut (
		.clk(clk), .resetN(resetN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.startOfFrame(startOfFrame), .collisionFrame(flags[4]), .collisionObstacle(flags[3]),
		.collisionSpring(flags[2]), .collisionFlipper(flags[1]), .collisionBumper(flags[0]),
		.hitEdgeCode(hitEdgeCode), .position(position), .positionValid(positionValid)
	);

	pinballChecker u_checker (
		.clk(clk), .resetN(resetN), .testName(testName), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.startOfFrame(startOfFrame), .collisionFrame(flags[4]), .collisionObstacle(flags[3]),
		.collisionSpring(flags[2]), .collisionFlipper(flags[1]), .collisionBumper(flags[0]),
		.hitEdgeCode(hitEdgeCode), .position(position), .positionValid(positionValid),
		.errorCount(errorCount), .positionChecks(positionChecks)
	);

	// Setup phase, access phase, idle. Starts and ends on a falling edge.
	task automatic apbTransfer(input logic write, input logic [3:0] addr, input logic [31:0] data);
		psel = 1'b1;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	// 16 cycles, with any collision eight cycles after the frame strobe.
	task automatic runFrame(input logic [4:0] hitFlags, input pinballPkg::edgeCodeT edges);
		startOfFrame = 1'b1;
		@(negedge clk);
		startOfFrame = 1'b0;
		repeat (7) @(negedge clk);
		flags = hitFlags;
		hitEdgeCode = edges;
		@(negedge clk);
		flags = '0;
		hitEdgeCode = '0;
		repeat (7) @(negedge clk);
	endtask

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Timeout after %0d cycles, the run did not finish", cycleCount);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h623e));
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		startOfFrame = 1'b0;
		flags = '0;
		hitEdgeCode = '0;
		testName = "init";
		cycleCount = 0;
		steps[0] = '{"reset", 0, 0, 0, 4'h0, 32'd0, 5'b00000, 4'b0000, 0, 4'd1};
		steps[1] = '{"flipperRead", 1, 1, 0, 4'h4, 32'd40, 5'b00000, 4'b0000, 0, 4'd1};
		steps[2] = '{"springRead", 1, 1, 1, 4'h8, 32'd0, 5'b00000, 4'b0000, 0, 4'd1};
		steps[3] = '{"freeFall", 0, 0, 0, 4'h0, 32'd0, 5'b00000, 4'b0000, 1, 4'd0};
		steps[4] = '{"wallFalling", 0, 0, 0, 4'h0, 32'd0, 5'b10000, 4'b0001, 0, 4'd3};
		steps[5] = '{"wallRising", 0, 0, 0, 4'h0, 32'd0, 5'b10000, 4'b0001, 0, 4'd1};
		steps[6] = '{"wallBumper", 0, 0, 0, 4'h0, 32'd0, 5'b10001, 4'b0100, 0, 4'd2};
		steps[7] = '{"flipper", 0, 0, 0, 4'h0, 32'd0, 5'b00010, 4'b0001, 0, 4'd2};
		steps[8] = '{"spring", 0, 0, 0, 4'h0, 32'd0, 5'b00100, 4'b0001, 0, 4'd2};
		steps[9] = '{"bumper", 1, 1, 0, 4'hC, 32'h0201FF01, 5'b00001, 4'b0000, 0, 4'd2};
		steps[10] = '{"pause", 1, 0, 0, 4'h0, 32'd1, 5'b00000, 4'b0000, 0, 4'd3};
		steps[11] = '{"restart", 1, 0, 0, 4'h0, 32'd3, 5'b00000, 4'b0000, 0, 4'd2};
		steps[12] = '{"resume", 1, 0, 0, 4'h0, 32'd0, 5'b00000, 4'b0000, 0, 4'd2};
		cycleLimit = 10 + 4;
		foreach (steps[i]) begin
			if (steps[i].randomFrames) begin
				steps[i].frames = 4'(2 + $urandom % 4);
			end
			if (steps[i].randomData) begin
				steps[i].data = -(32'sd64 + 32'($urandom % 128)); // Negative launch speed.
			end
			cycleLimit = cycleLimit + 16 * steps[i].frames + 3 * steps[i].doWrite +
				3 * steps[i].readBack;
		end
		cycleLimit = cycleLimit * 3 / 2;
		@(posedge resetN);
		@(negedge clk);
		foreach (steps[i]) begin
			testName = steps[i].name;
			if (steps[i].doWrite) begin
				apbTransfer(1'b1, steps[i].addr, steps[i].data);
			end
			if (steps[i].readBack) begin
				apbTransfer(1'b0, steps[i].addr, 32'd0);
			end
			for (int f = 0; f < steps[i].frames; f++) begin
				runFrame((f == 0) ? steps[i].flags : 5'b0, steps[i].edges);
			end
		end
		repeat (4) @(negedge clk);
		$display("Finished with %0d position checks and %0d errors", positionChecks, errorCount);
		if (errorCount == 0 && positionChecks > 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== build.f ====
source/pinballPkg.sv
source/apbRegisters.sv
source/collisionArbiter.sv
source/ballController.sv
source/positionPublisher.sv
source/pinballTop.sv
verification/clockGen.sv
verification/pinballChecker.sv
verification/pinballTb.sv

// ==== Bender.yml ====
package:
  name: pinball

sources:
  - source/pinballPkg.sv
  - source/apbRegisters.sv
  - source/collisionArbiter.sv
  - source/ballController.sv
  - source/positionPublisher.sv
  - source/pinballTop.sv
  - target: simulation
    files:
      - verification/clockGen.sv
      - verification/pinballChecker.sv
      - verification/pinballTb.sv
